//--- heapPkg.sv
//--------------------
// Heap package
// Action and error codes shared by the heap blocks and the testbench
//--------------------
package heapPkg;

  // Action codes, numbered as in the original memory block
  typedef enum logic [7:0] {
    clearHeap = 8'd1,                          // Zero all sizes and allocations
    write     = 8'd2,                          // Write an element
    read      = 8'd3,                          // Read an element
    size      = 8'd4,                          // Size of an array
    push      = 8'd14,                         // Append at the end
    pop       = 8'd15,                         // Remove from the end
    resize    = 8'd17,                         // Set the size directly
    alloc     = 8'd18,                         // Allocate an empty array
    free      = 8'd19,                         // Return an array for reuse
    add       = 8'd20,                         // Add, give new value
    addAfter  = 8'd21,                         // Add, give old value
    subtract  = 8'd22,                         // Subtract, give new value
    shiftLeft = 8'd24,                         // Shift left by operand
    orWith    = 8'd28,                         // Bitwise or
    xorWith   = 8'd29,                         // Bitwise xor
    andWith   = 8'd30                          // Bitwise and
  } heapAction;

  //--------------------
  // Error codes, one per response
  typedef enum logic [3:0] {
    none         = 4'd0,                       // Success
    notAllocated = 4'd1,                       // Array not allocated, also double free
    outOfBounds  = 4'd2,                       // Index at or past size
    arrayFull    = 4'd3,                       // Push to a full array
    arrayEmpty   = 4'd4,                       // Pop from an empty array
    outOfMemory  = 4'd5,                       // No array left to allocate
    tooLarge     = 4'd6                        // Resize past array length
  } heapError;

endpackage

//--- requestQueue.sv
//--------------------
// Request queue
// Circular buffer of heap requests, one upstream credit per dequeue
//--------------------
`timescale 1ns/1ns

module requestQueue import heapPkg::*; #(
  parameter int AddressBits  = 2,
  parameter int IndexBits    = 2,
  parameter int DataBits     = 12,
  parameter int RequestDepth = 4
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   push,         // Request accepted this cycle
  input  heapAction              pushAction,
  input  logic [AddressBits-1:0] pushArray,
  input  logic [IndexBits-1:0]   pushIndex,
  input  logic [DataBits-1:0]    pushData,
  input  logic                   pop,          // Executor takes the head
  output logic                   notEmpty,
  output heapAction              headAction,
  output logic [AddressBits-1:0] headArray,
  output logic [IndexBits-1:0]   headIndex,
  output logic [DataBits-1:0]    headData,
  output logic                   credit        // One credit back per pop
);

  localparam int PtrBits   = (RequestDepth > 1) ? $clog2(RequestDepth) : 1;
  localparam int CountBits = $clog2(RequestDepth + 1);

  heapAction              actions [RequestDepth];      // Queue payload
  logic [AddressBits-1:0] arrays  [RequestDepth];
  logic [IndexBits-1:0]   indices [RequestDepth];
  logic [DataBits-1:0]    datas   [RequestDepth];

  logic [PtrBits-1:0]   writePtr, readPtr;
  logic [CountBits-1:0] count;                 // Entries held
  logic                 full;

  assign full       = count == CountBits'(RequestDepth);
  assign notEmpty   = count != '0;
  assign headAction = actions[readPtr];        // Head visible a cycle after push
  assign headArray  = arrays[readPtr];
  assign headIndex  = indices[readPtr];
  assign headData   = datas[readPtr];

  always_ff @(posedge clock) begin
    if (push) begin                            // Payload, no reset
      actions[writePtr] <= pushAction;
      arrays[writePtr]  <= pushArray;
      indices[writePtr] <= pushIndex;
      datas[writePtr]   <= pushData;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      writePtr <= '0;
      readPtr  <= '0;
      count    <= '0;
      credit   <= 1'b0;
    end else begin
      credit <= pop;                           // Returned with the response
      if (push) writePtr <= (writePtr == PtrBits'(RequestDepth - 1)) ? '0 : writePtr + 1'b1;
      if (pop)  readPtr  <= (readPtr == PtrBits'(RequestDepth - 1)) ? '0 : readPtr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;               // Both or neither
      endcase
    end
  end

  // Requester holds no credit when the queue is full
  assert property (@(posedge clock) disable iff (reset) !(push && full))
    else $error("request pushed into a full queue");
  // Executor only pops what is there
  assert property (@(posedge clock) disable iff (reset) !(pop && !notEmpty))
    else $error("pop from an empty request queue");

endmodule

//--- arrayTable.sv
//--------------------
// Array table
// Allocation flags, sizes, free stack and allocation counter
//--------------------
`timescale 1ns/1ns

module arrayTable #(
  parameter int AddressBits = 2,
  parameter int IndexBits   = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   clear,        // Same effect as reset
  input  logic [AddressBits-1:0] lookArray,    // Array under request
  output logic                   allocated,
  output logic [IndexBits:0]     size,
  output logic [AddressBits-1:0] nextArray,    // Number the next alloc gives
  output logic                   allocOk,
  input  logic                   setSize,
  input  logic [IndexBits:0]     newSize,
  input  logic                   doAlloc,
  input  logic                   doFree
);

  localparam int Arrays = 2 ** AddressBits;

  logic                   allocFlags [Arrays];  // Currently allocated
  logic [IndexBits:0]     sizes      [Arrays];  // Elements in use
  logic [AddressBits-1:0] freeStack  [Arrays];  // Freed numbers, LIFO
  logic [AddressBits:0]   freeTop;              // Stack depth
  logic [AddressBits:0]   allocCount;           // Never-used numbers taken
  logic [AddressBits-1:0] topIndex;
  logic                   stackHasEntry;

  assign stackHasEntry = freeTop != '0;
  assign topIndex      = freeTop[AddressBits-1:0] - 1'b1;

  //--------------------
  // Lookup, combinational
  assign allocated = allocFlags[lookArray];
  assign size      = sizes[lookArray];
  assign nextArray = stackHasEntry ? freeStack[topIndex]  // Reuse last freed
                                   : allocCount[AddressBits-1:0];
  assign allocOk   = stackHasEntry || (allocCount < (AddressBits + 1)'(Arrays));

  //--------------------
  // Update at the edge
  always_ff @(posedge clock) begin
    if (reset || clear) begin
      freeTop    <= '0;
      allocCount <= '0;
      for (int i = 0; i < Arrays; i++) begin
        allocFlags[i] <= 1'b0;
        sizes[i]      <= '0;
      end
    end else begin
      if (setSize) sizes[lookArray] <= newSize;
      if (doAlloc) begin
        allocFlags[nextArray] <= 1'b1;
        sizes[nextArray]      <= '0;           // New array starts empty
        if (stackHasEntry) freeTop <= freeTop - 1'b1;
        else               allocCount <= allocCount + 1'b1;
      end
      if (doFree) begin
        allocFlags[lookArray]                  <= 1'b0;
        freeStack[freeTop[AddressBits-1:0]]   <= lookArray;
        freeTop                                <= freeTop + 1'b1;
      end
    end
  end

  // Double free is refused upstream, so the stack never passes Arrays
  assert property (@(posedge clock) disable iff (reset)
    doFree |-> freeTop < (AddressBits + 1)'(Arrays))
    else $error("free stack overflow");

endmodule

//--- elementStore.sv
//--------------------
// Element store
// Array elements with the read-modify-write datapath
//--------------------
`timescale 1ns/1ns

module elementStore import heapPkg::*; #(
  parameter int AddressBits = 2,
  parameter int IndexBits   = 2,
  parameter int DataBits    = 12
) (
  input  logic                   clock,
  input  heapAction              action,       // Selects the new value
  input  logic [AddressBits-1:0] array,
  input  logic [IndexBits-1:0]   index,
  input  logic [DataBits-1:0]    operand,
  input  logic                   enable,       // Write newValue at the edge
  output logic [DataBits-1:0]    oldValue,
  output logic [DataBits-1:0]    newValue
);

  localparam int Arrays      = 2 ** AddressBits;
  localparam int ArrayLength = 2 ** IndexBits;

  logic [DataBits-1:0] cells [Arrays][ArrayLength];  // Fixed block per array

  assign oldValue = cells[array][index];       // Current element

  always_comb begin
    case (action)
      write, push:     newValue = operand;
      add, addAfter:   newValue = oldValue + operand;
      subtract:        newValue = oldValue - operand;
      orWith:          newValue = oldValue | operand;
      andWith:         newValue = oldValue & operand;
      xorWith:         newValue = oldValue ^ operand;
      shiftLeft:       newValue = oldValue << operand;
      default:         newValue = oldValue;    // Nothing to change
    endcase
  end

  always_ff @(posedge clock) begin
    if (enable) cells[array][index] <= newValue;
  end

endmodule

//--- heapExecute.sv
//--------------------
// Heap executor
// Decodes the head request, checks errors, steers table and store
//--------------------
`timescale 1ns/1ns

module heapExecute import heapPkg::*; #(
  parameter int AddressBits     = 2,
  parameter int IndexBits       = 2,
  parameter int DataBits        = 12,
  parameter int ResponseCredits = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   notEmpty,     // Queue side
  input  heapAction              headAction,
  input  logic [AddressBits-1:0] headArray,
  input  logic [IndexBits-1:0]   headIndex,
  input  logic [DataBits-1:0]    headData,
  output logic                   pop,
  input  logic                   allocated,    // Table side
  input  logic [IndexBits:0]     size,
  input  logic [AddressBits-1:0] nextArray,
  input  logic                   allocOk,
  output logic                   clear,
  output logic                   setSize,
  output logic [IndexBits:0]     newSize,
  output logic                   doAlloc,
  output logic                   doFree,
  output logic [IndexBits-1:0]   storeIndex,   // Store side
  output logic                   storeEnable,
  input  logic [DataBits-1:0]    oldValue,
  input  logic [DataBits-1:0]    newValue,
  input  logic                   respCredit,   // Response side
  output logic                   respValid,
  output logic [DataBits-1:0]    respData,
  output heapError               respError
);

  localparam int ArrayLength = 2 ** IndexBits;
  localparam int CreditBits  = $clog2(ResponseCredits + 1);

  logic [CreditBits-1:0] credits;              // Consumer slots free
  logic                  isModify, isPush, isPop, isWrite, ok, grows;
  heapError              error;
  logic [DataBits-1:0]   data;

  // The size and pop ports shadow the package literals of the same name
  assign isPush   = headAction == push;
  assign isPop    = headAction == heapPkg::pop;
  assign isWrite  = headAction == write;
  assign isModify = headAction inside {add, addAfter, subtract, orWith,
                                       andWith, xorWith, shiftLeft};
  assign pop      = notEmpty && credits != '0; // Issue only with a credit
  assign grows    = {1'b0, headIndex} >= size;

  //--------------------
  // Error checks, first match wins
  always_comb begin
    if (!(headAction inside {clearHeap, alloc}) && !allocated)          error = notAllocated;
    else if ((headAction == read || isModify) && grows)                 error = outOfBounds;
    else if (isPush && size == (IndexBits + 1)'(ArrayLength))           error = arrayFull;
    else if (isPop && size == '0)                                       error = arrayEmpty;
    else if (headAction == resize && headData > DataBits'(ArrayLength)) error = tooLarge;
    else if (headAction == alloc && !allocOk)                           error = outOfMemory;
    else                                                                error = none;
  end

  assign ok = pop && error == none;            // Failed requests change nothing

  //--------------------
  // Steering
  assign clear       = pop && headAction == clearHeap;
  assign doAlloc     = ok && headAction == alloc;
  assign doFree      = ok && headAction == free;
  assign storeEnable = ok && (isWrite || isPush || isModify);
  assign setSize     = ok && ((isWrite && grows) || isPush || isPop || headAction == resize);

  always_comb begin
    storeIndex = headIndex;
    newSize    = headData[IndexBits:0];        // Resize
    if (isPush) begin
      storeIndex = size[IndexBits-1:0];        // Append at old size
      newSize    = size + 1'b1;
    end else if (isPop) begin
      storeIndex = IndexBits'(size - 1'b1);    // Element at new size
      newSize    = size - 1'b1;
    end else if (isWrite) begin
      newSize    = {1'b0, headIndex} + 1'b1;
    end
  end

  always_comb begin
    case (headAction)
      write, push, resize:  data = headData;
      read, heapPkg::pop:   data = oldValue;
      heapPkg::size:        data = DataBits'(size);
      alloc:                data = DataBits'(nextArray);
      free:                 data = DataBits'(headArray);
      addAfter:             data = oldValue;   // Value before the add
      add, subtract, orWith, andWith, xorWith, shiftLeft:
                            data = newValue;
      default:              data = '0;
    endcase
  end

  //--------------------
  // Response register and credits
  always_ff @(posedge clock) begin
    respData  <= (error == none) ? data : '0;
    respError <= error;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      respValid <= 1'b0;
      credits   <= CreditBits'(ResponseCredits);
    end else begin
      respValid <= pop;                        // One cycle after the pop
      case ({pop, respCredit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Consumer never returns more slots than it has
  assert property (@(posedge clock) disable iff (reset)
    credits <= CreditBits'(ResponseCredits))
    else $error("response credits above consumer buffer size");

endmodule

//--- heapMemory.sv
//--------------------
// Heap memory top
// Request queue, executor, array table and element store
//--------------------
`timescale 1ns/1ns

module heapMemory import heapPkg::*; #(
  parameter int AddressBits     = 2,
  parameter int IndexBits       = 2,
  parameter int DataBits        = 12,
  parameter int RequestDepth    = 4,
  parameter int ResponseCredits = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   reqValid,     // Upstream, credit based
  input  heapAction              reqAction,
  input  logic [AddressBits-1:0] reqArray,
  input  logic [IndexBits-1:0]   reqIndex,
  input  logic [DataBits-1:0]    reqData,
  output logic                   reqCredit,
  output logic                   respValid,    // Downstream, credit based
  output logic [DataBits-1:0]    respData,
  output heapError               respError,
  input  logic                   respCredit
);

  logic                   queueNotEmpty, queuePop;
  heapAction              headAction;
  logic [AddressBits-1:0] headArray, nextArray;
  logic [IndexBits-1:0]   headIndex, storeIndex;
  logic [DataBits-1:0]    headData, oldValue, newValue;
  logic                   allocated, allocOk, tableClear, setSize, doAlloc, doFree;
  logic [IndexBits:0]     arraySize, newSize;
  logic                   storeEnable;

  requestQueue #(.AddressBits(AddressBits), .IndexBits(IndexBits), .DataBits(DataBits),
                 .RequestDepth(RequestDepth)) queue (
    .clock, .reset,
    .push(reqValid), .pushAction(reqAction), .pushArray(reqArray),
    .pushIndex(reqIndex), .pushData(reqData),
    .pop(queuePop), .notEmpty(queueNotEmpty), .headAction, .headArray,
    .headIndex, .headData, .credit(reqCredit));

  heapExecute #(.AddressBits(AddressBits), .IndexBits(IndexBits), .DataBits(DataBits),
                .ResponseCredits(ResponseCredits)) execute (
    .clock, .reset,
    .notEmpty(queueNotEmpty), .headAction, .headArray, .headIndex, .headData,
    .pop(queuePop),
    .allocated, .size(arraySize), .nextArray, .allocOk,
    .clear(tableClear), .setSize, .newSize, .doAlloc, .doFree,
    .storeIndex, .storeEnable, .oldValue, .newValue,
    .respCredit, .respValid, .respData, .respError);

  arrayTable #(.AddressBits(AddressBits), .IndexBits(IndexBits)) table0 (
    .clock, .reset, .clear(tableClear), .lookArray(headArray),
    .allocated, .size(arraySize), .nextArray, .allocOk,
    .setSize, .newSize, .doAlloc, .doFree);

  elementStore #(.AddressBits(AddressBits), .IndexBits(IndexBits),
                 .DataBits(DataBits)) store (
    .clock, .action(headAction), .array(headArray), .index(storeIndex),
    .operand(headData), .enable(storeEnable), .oldValue, .newValue);

endmodule

//--- heapMemoryTb.sv
//--------------------
// Heap memory testbench
// Replays the request file under random response credits, checks responses
//--------------------
`timescale 1ns/1ns

module heapMemoryTb import heapPkg::*; ();

  localparam int AddressBits     = 2;
  localparam int IndexBits       = 2;
  localparam int DataBits        = 12;
  localparam int RequestDepth    = 4;
  localparam int ResponseCredits = 2;
  localparam int MaxRequests     = 64;
  localparam int TimeoutCycles   = 4000;      // Whole run, in clock cycles

  logic                   clock, reset;
  logic                   reqValid, reqCredit;
  heapAction              reqAction;
  logic [AddressBits-1:0] reqArray;
  logic [IndexBits-1:0]   reqIndex;
  logic [DataBits-1:0]    reqData;
  logic                   respValid, respCredit;
  logic [DataBits-1:0]    respData;
  heapError               respError;

  logic [15:0] stimWords [6*MaxRequests];     // Six columns per request
  int seed, total, sent, received, passed, failed;
  int upCredits;                              // Request credits held
  int held;                                   // Responses in consumer buffer
  int holdOff;                                // Cycles left with credits withheld
  int cycles;

  always #50 clock = ~clock;                  // 100 ns period

  heapMemory #(.AddressBits(AddressBits), .IndexBits(IndexBits), .DataBits(DataBits),
               .RequestDepth(RequestDepth), .ResponseCredits(ResponseCredits)) UUT (
    .clock, .reset, .reqValid, .reqAction, .reqArray, .reqIndex, .reqData, .reqCredit,
    .respValid, .respData, .respError, .respCredit);

  //--------------------
  // Compare one response with its line of the file
  task automatic checkResponse();
    heapAction           act;
    logic [DataBits-1:0] expData;
    heapError            expError;
    string               testName;
    logic                ok;
    act      = heapAction'(stimWords[6*received][7:0]);
    expData  = stimWords[6*received+4][DataBits-1:0];
    expError = heapError'(stimWords[6*received+5][3:0]);
    testName = $sformatf("request %0d %s", received, act.name());
    ok = 1'b1;
    assert (respData === expData && respError === expError)
      else begin
        ok = 1'b0;
        failed++;
        $display("Error %s expected %h %s actual %h %s", testName, expData,
                 expError.name(), respData, respError.name());
      end
    if (ok) begin
      passed++;
      $display("Test %s ok", testName);
    end
    received++;
  endtask

  // Response lands in the consumer buffer
  task automatic takeResponse();
    held++;
    assert (held <= ResponseCredits)
      else begin
        failed++;
        $display("A response arrived while the design held no response credit");
      end
    checkResponse();
  endtask

  // Next request goes out only on a held credit
  task automatic driveRequest();
    reqValid = 1'b0;
    if (sent < total && upCredits > 0) begin
      reqValid  = 1'b1;
      reqAction = heapAction'(stimWords[6*sent][7:0]);
      reqArray  = stimWords[6*sent+1][AddressBits-1:0];
      reqIndex  = stimWords[6*sent+2][IndexBits-1:0];
      reqData   = stimWords[6*sent+3][DataBits-1:0];
      upCredits--;
      sent++;
    end
  endtask

  // Free a buffer slot now and then, with long pauses
  task automatic driveCredit();
    respCredit = 1'b0;
    if (holdOff > 0) holdOff--;
    else if (held > 0 && ($random(seed) & 3) == 0) begin
      respCredit = 1'b1;
      held--;
    end
    if (($random(seed) & 31) == 0) holdOff = 20 + ($random(seed) & 15);
  endtask

  //--------------------
  initial begin
    seed       = 53570;
    clock      = 1'b0;
    reset      = 1'b1;
    reqValid   = 1'b0;
    reqAction  = clearHeap;
    reqArray   = '0;
    reqIndex   = '0;
    reqData    = '0;
    respCredit = 1'b0;
    {total, sent, received, passed, failed, held, holdOff, cycles} = '0;
    upCredits  = RequestDepth;
    $readmemh("heapStimulus.txt", stimWords);
    while (total < MaxRequests && stimWords[6*total] != 16'h0000) total++;  // Up to end marker

    for (int i = 0; i < 16; i++) @(negedge clock);
    reset = 1'b0;

    while (received < total && cycles < TimeoutCycles) begin
      @(negedge clock);                       // Outputs settled, inputs change here
      cycles++;
      if (reqCredit) upCredits++;
      assert (upCredits <= RequestDepth)
        else begin
          failed++;
          $display("The design returned more request credits than requests sent");
        end
      if (respValid) takeResponse();
      driveRequest();
      driveCredit();
    end

    if (received < total) begin
      failed++;
      $display("Timed out with %0d of %0d responses received", received, total);
    end
    $display("Tests passed %0d failed %0d of %0d requests", passed, failed, total);
    if (failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- heapStimulus.txt
// Hex columns: action, array, index, data, expected response data, expected error
// A line with action 00 ends the list
12 0 0 000 000 0  // Four allocations
12 0 0 000 001 0
12 0 0 000 002 0
12 0 0 000 003 0
12 0 0 000 000 5  // Out of memory
13 2 0 000 002 0
13 1 0 000 001 0
12 0 0 000 001 0  // Last freed comes back first
12 0 0 000 002 0
02 1 2 0AB 0AB 0  // Write grows size to 3
04 1 0 000 003 0
03 1 2 000 0AB 0
03 1 3 000 000 2
11 1 0 004 004 0
11 1 0 005 000 6
0E 2 0 011 011 0  // Fill array 2
0E 2 0 022 022 0
0E 2 0 033 033 0
0E 2 0 044 044 0
0E 2 0 055 000 3
0F 2 0 000 044 0
0F 2 0 000 033 0
0F 2 0 000 022 0
0F 2 0 000 011 0
0F 2 0 000 000 4
02 3 0 0F0 0F0 0  // Modify chain on array 3
14 3 0 F20 010 0
16 3 0 030 FE0 0
1C 3 0 00F FEF 0
1E 3 0 F3C F2C 0
1D 3 0 0FF FD3 0
18 3 0 004 D30 0
15 3 0 100 D30 0
03 3 0 000 E30 0
13 2 0 000 002 0  // Freed array refuses access
03 2 0 000 000 1
13 2 0 000 000 1
0E 2 0 001 000 1
01 0 0 000 000 0
12 0 0 000 000 0
04 1 0 000 000 1
00 0 0 000 000 0

//--- verilog.f
heapPkg.sv
requestQueue.sv
arrayTable.sv
elementStore.sv
heapExecute.sv
heapMemory.sv
heapMemoryTb.sv

//--- runSim.sh
#!/bin/bash
# Build the heap memory testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module heapMemoryTb \
  > build.log 2>&1 &&
  ./obj_dir/VheapMemoryTb > sim.log 2>&1 ||
  { echo "Build or simulation did not complete"; cat build.log; exit 1; }
cat sim.log
! grep -q ">>> FAIL" sim.log
